// File: sim/spm_tests.txt
// Columns: group requester op idx tag be wdata abort tid, all hex
// op 0 is a load and 1 a store; lines of one group are raised together
// Untouched words read zero, raised while the sweep runs
0 0 0 3 5 0 00000000 0 1
0 1 0 f f 0 00000000 0 2
0 2 0 0 0 0 00000000 0 3
// Full-word store and load back
1 1 1 2 3 f deadbeef 0 4
2 1 0 2 3 0 00000000 0 5
// Partial store then load, granted by requester number
3 2 0 2 3 0 00000000 0 6
3 0 1 2 3 5 11223344 0 7
// Base word for the abort cases
4 0 1 7 a f 12345678 0 8
// Aborted store with its own tag, load right behind it
5 0 1 7 b f 55555555 1 9
5 1 0 7 a 0 00000000 0 a
// Aborted store left the word untouched
6 0 0 7 b 0 00000000 0 b
6 2 0 7 a 0 00000000 0 c
// Aborted load gives no response
7 0 0 1 0 0 00000000 1 d
7 1 1 1 0 c a5a5a5a5 0 e
7 2 0 1 0 0 00000000 0 f
// Two byte stores from different requesters
8 2 1 e 4 8 77000000 0 0
8 1 1 e 4 1 00000099 0 1
8 0 0 e 4 0 00000000 0 2
9 2 0 e 4 0 00000000 0 3
// Last word of the array
a 0 1 f f f ffffffff 0 4
a 1 1 f f 2 0000ab00 0 5
a 2 0 f f 0 00000000 0 6
// Read back earlier words
b 0 0 2 3 0 00000000 0 7
b 1 0 f f 0 00000000 0 8
b 2 0 1 0 0 00000000 0 9
// Store and load from the same group
c 1 0 0 8 0 00000000 0 a
c 0 1 0 8 6 00c0ff00 0 b

// File: tb.f
hw/spm_pkg.sv
hw/spm_req_if.sv
hw/spm_fixed_prio_arb.sv
hw/spm_core_arbiter.sv
hw/spm_data_store.sv
hw/spm_top.sv
sim/tb_spm.sv

// File: sim/tb_spm.sv
`timescale 1ns/1ps

module tb_spm;

    // Room for this many request lines
    localparam int unsigned NV = 64;

    // One accepted request on its way through the store
    typedef struct packed {
        logic              vld;
        logic              abort;
        spm_pkg::spm_sid_t src;
        spm_pkg::spm_rsp_t rsp;
    } pipe_t;

    logic              clk_i;
    logic              rst_ni;
    logic              req_valid [spm_pkg::NREQ-1:0];
    logic              req_ready [spm_pkg::NREQ-1:0];
    spm_pkg::spm_req_t req       [spm_pkg::NREQ-1:0];
    logic              req_abort [spm_pkg::NREQ-1:0];
    spm_pkg::spm_tag_t req_tag   [spm_pkg::NREQ-1:0];
    logic              rsp_valid [spm_pkg::NREQ-1:0];
    spm_pkg::spm_rsp_t rsp;

    // Nine words per line, group requester op idx tag be wdata abort tid
    logic [31:0]                tests_mem [9*NV];
    // Predicted memory contents
    logic [spm_pkg::DATA_W-1:0] ref_mem [spm_pkg::NWORDS];

    // Current group, per requester
    spm_pkg::spm_req_t grp_req   [spm_pkg::NREQ];
    spm_pkg::spm_tag_t grp_tag   [spm_pkg::NREQ];
    logic              grp_abort [spm_pkg::NREQ];
    logic              grp_has   [spm_pkg::NREQ];

    pipe_t       acc_next;
    pipe_t       stage_a;
    pipe_t       stage_b;
    int unsigned cycle;
    int          remaining;
    logic [31:0] rng;

    spm_top DUT (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .req_abort_i (req_abort),
        .req_tag_i   (req_tag),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    always #20 clk_i = ~clk_i;

    task automatic fail_stop();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        fail_stop();
    endtask

    task automatic check_rsp(input spm_pkg::spm_rsp_t got, input spm_pkg::spm_rsp_t exp);
        if (got !== exp) begin
            $display("MISMATCH rsp_o: got %h expected %h", got, exp);
            fail_stop();
        end
    endtask

    task automatic check_sid(input string name, input spm_pkg::spm_sid_t got,
                             input spm_pkg::spm_sid_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            fail_stop();
        end
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_line(input int unsigned line);
        int unsigned base;
        int unsigned r;
        base = 9 * line;
        r    = tests_mem[base+1];
        grp_req[r].op    = spm_pkg::spm_op_e'(tests_mem[base+2][0]);
        grp_req[r].idx   = tests_mem[base+3][spm_pkg::IDX_W-1:0];
        grp_tag[r]       = tests_mem[base+4][spm_pkg::TAG_W-1:0];
        grp_req[r].be    = tests_mem[base+5][spm_pkg::BE_W-1:0];
        grp_req[r].wdata = tests_mem[base+6];
        grp_abort[r]     = tests_mem[base+7][0];
        grp_req[r].tid   = tests_mem[base+8][spm_pkg::TID_W-1:0];
        grp_req[r].sid   = spm_pkg::spm_sid_t'(r);
        grp_has[r]       = 1'b1;
        remaining++;
    endtask

    // Predict the response and apply stores in grant order
    task automatic accept(input int r);
        logic [spm_pkg::ADDR_W-1:0] addr;
        int                         b;
        addr = {grp_tag[r], grp_req[r].idx};
        acc_next.vld       = 1'b1;
        acc_next.abort     = grp_abort[r];
        acc_next.src       = spm_pkg::spm_sid_t'(r);
        acc_next.rsp.sid   = grp_req[r].sid;
        acc_next.rsp.tid   = grp_req[r].tid;
        acc_next.rsp.op    = grp_req[r].op;
        acc_next.rsp.rdata = '0;
        if (!grp_abort[r]) begin
            if (grp_req[r].op == spm_pkg::LOAD) begin
                acc_next.rsp.rdata = ref_mem[addr];
            end else begin
                for (b = 0; b < spm_pkg::BE_W; b++) begin
                    if (grp_req[r].be[b]) begin
                        ref_mem[addr][8*b +: 8] = grp_req[r].wdata[8*b +: 8];
                    end
                end
            end
        end
        remaining--;
    endtask

    // One clock cycle, from falling edge to falling edge
    task automatic tick(input logic launch);
        int   r;
        int   win;
        int   got;
        logic exp_v;
        @(negedge clk_i);
        cycle++;
        stage_b      = stage_a;
        stage_a      = acc_next;
        acc_next.vld = 1'b0;
        // Accepted two edges ago, unless aborted
        for (r = 0; r < spm_pkg::NREQ; r++) begin
            exp_v = stage_b.vld && !stage_b.abort && (stage_b.src == spm_pkg::spm_sid_t'(r));
            check_ready($sformatf("rsp_valid_o[%0d]", r), rsp_valid[r], exp_v);
        end
        if (stage_b.vld && !stage_b.abort) begin
            check_rsp(rsp, stage_b.rsp);
        end
        // Tag phase of the last accept, zero elsewhere
        for (r = 0; r < spm_pkg::NREQ; r++) begin
            req_tag[r]   = '0;
            req_abort[r] = 1'b0;
        end
        if (stage_a.vld) begin
            req_valid[stage_a.src] = 1'b0;
            req_tag[stage_a.src]   = grp_tag[stage_a.src];
            req_abort[stage_a.src] = grp_abort[stage_a.src];
        end
        if (launch) begin
            for (r = 0; r < spm_pkg::NREQ; r++) begin
                if (grp_has[r]) begin
                    req[r]       = grp_req[r];
                    req_valid[r] = 1'b1;
                end
            end
        end
        #1;
        // Lowest valid requester should win once the sweep is over
        win = -1;
        got = -1;
        for (r = 0; r < spm_pkg::NREQ; r++) begin
            if (req_valid[r] && (win < 0)) begin
                win = r;
            end
        end
        // No ready for losers, none at all during the sweep
        for (r = 0; r < spm_pkg::NREQ; r++) begin
            if ((r != win) || (cycle < spm_pkg::NWORDS)) begin
                check_ready($sformatf("req_ready_o[%0d]", r), req_ready[r], 1'b0);
            end
            if (req_ready[r] && (got < 0)) begin
                got = r;
            end
        end
        // Winner gets accepted in ascending requester order
        if ((win >= 0) && (cycle >= spm_pkg::NWORDS)) begin
            check_sid("grant sid", spm_pkg::spm_sid_t'(got), spm_pkg::spm_sid_t'(win));
        end
        if (got >= 0) begin
            accept(got);
        end
    endtask

    initial begin
        int unsigned line;
        logic [31:0] grp;
        int          guard;
        int          gap;
        int          i;
        clk_i  = 1'b0;
        rst_ni = 1'b0;
        for (i = 0; i < spm_pkg::NREQ; i++) begin
            req_valid[i] = 1'b0;
            req[i]       = '0;
            req_abort[i] = 1'b0;
            req_tag[i]   = '0;
            grp_has[i]   = 1'b0;
        end
        acc_next  = '0;
        stage_a   = '0;
        stage_b   = '0;
        cycle     = 0;
        remaining = 0;
        rng       = 32'h964f;
        for (i = 0; i < spm_pkg::NWORDS; i++) begin
            ref_mem[i] = '0;
        end
        // Unused entries mark the end of the vectors
        for (i = 0; i < 9 * NV; i++) begin
            tests_mem[i] = 32'hffff_ffff;
        end
        $readmemh("sim/spm_tests.txt", tests_mem);
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        line = 0;
        while ((line < NV) && (tests_mem[9*line] != 32'hffff_ffff)) begin
            grp       = tests_mem[9*line];
            remaining = 0;
            for (i = 0; i < spm_pkg::NREQ; i++) begin
                grp_has[i] = 1'b0;
            end
            while ((line < NV) && (tests_mem[9*line] == grp)) begin
                load_line(line);
                line++;
            end
            tick(1'b1);
            // First group also spans the clearing sweep
            guard = 0;
            while (remaining > 0) begin
                if (guard > spm_pkg::NWORDS + 16) begin
                    timeout_fail("a request accept");
                end else begin
                    tick(1'b0);
                    guard++;
                end
            end
            guard = 0;
            while (acc_next.vld || stage_a.vld) begin
                if (guard > 8) begin
                    timeout_fail("the responses to drain");
                end else begin
                    tick(1'b0);
                    guard++;
                end
            end
            rng = next_rand(rng);
            gap = rng % 4;
            repeat (gap) tick(1'b0);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: hw/spm_top.sv
`timescale 1ns/1ps

module spm_top (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Requesters, first phase
    input  logic                req_valid_i [spm_pkg::NREQ-1:0],
    output logic                req_ready_o [spm_pkg::NREQ-1:0],
    input  spm_pkg::spm_req_t   req_i       [spm_pkg::NREQ-1:0],

    // Requesters, second phase
    input  logic                req_abort_i [spm_pkg::NREQ-1:0],
    input  spm_pkg::spm_tag_t   req_tag_i   [spm_pkg::NREQ-1:0],

    // Responses, one valid per requester on a shared bus
    output logic                rsp_valid_o [spm_pkg::NREQ-1:0],
    output spm_pkg::spm_rsp_t   rsp_o
);

    // Store response before demux
    logic              store_rsp_valid;
    spm_pkg::spm_rsp_t store_rsp;

    // Granted request path
    spm_req_if u_req_if ();

    // Requester arbitration and response routing
    spm_core_arbiter u_core_arbiter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .core_req_valid_i  (req_valid_i),
        .core_req_ready_o  (req_ready_o),
        .core_req_i        (req_i),
        .core_req_abort_i  (req_abort_i),
        .core_req_tag_i    (req_tag_i),
        .store_rsp_valid_i (store_rsp_valid),
        .store_rsp_i       (store_rsp),
        .core_rsp_valid_o  (rsp_valid_o),
        .core_rsp_o        (rsp_o),
        .arb_o             (u_req_if.arb)
    );

    // Scratchpad array
    spm_data_store u_data_store (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (u_req_if.store),
        .rsp_valid_o (store_rsp_valid),
        .rsp_o       (store_rsp)
    );

endmodule

// File: hw/spm_data_store.sv
`timescale 1ns/1ps

module spm_data_store (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Granted request and its tag phase
    spm_req_if.store           req_i,

    // Response, one cycle after the tag phase
    output logic               rsp_valid_o,
    output spm_pkg::spm_rsp_t  rsp_o
);

    // Word array
    logic [spm_pkg::DATA_W-1:0] mem [spm_pkg::NWORDS];

    // Clearing sweep after reset
    logic                       clr_busy_q;
    logic [spm_pkg::ADDR_W-1:0] clr_cnt_q;

    // Stage 1, request waiting for its tag
    logic                       s1_valid_q;
    spm_pkg::spm_req_t          s1_req_q;

    // Stage 2, joined with the tag
    logic                       s2_go;
    logic                       s2_wr;
    logic [spm_pkg::ADDR_W-1:0] s2_addr;

    // Response register
    logic                       rsp_valid_q;
    spm_pkg::spm_rsp_t          rsp_q;

    // No accepts while the sweep runs
    assign req_i.ready = !clr_busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            clr_busy_q <= 1'b1;
            clr_cnt_q  <= '0;
        end else if (clr_busy_q) begin
            clr_cnt_q <= clr_cnt_q + 1'b1;
            // Last word cleared
            if (clr_cnt_q == spm_pkg::ADDR_W'(spm_pkg::NWORDS - 1)) begin
                clr_busy_q <= 1'b0;
            end
        end
    end

    // Latch the request on transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_i.valid && req_i.ready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid && req_i.ready) begin
            s1_req_q <= req_i.req;
        end
    end

    // Tag arrives now, abort kills the access
    assign s2_go   = s1_valid_q && !req_i.abort;
    assign s2_wr   = s2_go && (s1_req_q.op == spm_pkg::STORE);
    assign s2_addr = {req_i.tag, s1_req_q.idx};

    // Array writes, sweep and byte-masked stores never overlap
    always_ff @(posedge clk_i) begin
        if (clr_busy_q) begin
            mem[clr_cnt_q] <= '0;
        end else if (s2_wr) begin
            for (int b = 0; b < spm_pkg::BE_W; b++) begin
                if (s1_req_q.be[b]) begin
                    mem[s2_addr][8*b +: 8] <= s1_req_q.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= s2_go;
        end
    end

    // Response payload, old word on loads
    always_ff @(posedge clk_i) begin
        if (s2_go) begin
            rsp_q.sid <= s1_req_q.sid;
            rsp_q.tid <= s1_req_q.tid;
            rsp_q.op  <= s1_req_q.op;
            if (s1_req_q.op == spm_pkg::LOAD) begin
                rsp_q.rdata <= mem[s2_addr];
            end else begin
                rsp_q.rdata <= '0;
            end
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // Sweep and responses are exclusive
    a_no_rsp_in_clear: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        clr_busy_q |-> !rsp_valid_o
    );

endmodule

// File: hw/spm_core_arbiter.sv
`timescale 1ns/1ps

module spm_core_arbiter (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Requesters, first phase
    input  logic                core_req_valid_i [spm_pkg::NREQ-1:0],
    output logic                core_req_ready_o [spm_pkg::NREQ-1:0],
    input  spm_pkg::spm_req_t   core_req_i       [spm_pkg::NREQ-1:0],

    // Requesters, second phase
    input  logic                core_req_abort_i [spm_pkg::NREQ-1:0],
    input  spm_pkg::spm_tag_t   core_req_tag_i   [spm_pkg::NREQ-1:0],

    // Responses from the store
    input  logic                store_rsp_valid_i,
    input  spm_pkg::spm_rsp_t   store_rsp_i,

    // Responses to the requesters
    output logic                core_rsp_valid_o [spm_pkg::NREQ-1:0],
    output spm_pkg::spm_rsp_t   core_rsp_o,

    // Granted request towards the store
    spm_req_if.arb              arb_o
);

    logic [spm_pkg::NREQ-1:0]             valid_vec;
    logic [spm_pkg::NREQ-1:0]             gnt_d;
    logic [spm_pkg::NREQ-1:0]             gnt_q;
    logic [$bits(spm_pkg::spm_req_t)-1:0] req_acc;
    logic [spm_pkg::TAG_W-1:0]            tag_acc;
    logic                                 abort_acc;

    // Pack valids for the arbiter, ready only to the winner
    always_comb begin
        for (int i = 0; i < spm_pkg::NREQ; i++) begin
            valid_vec[i]        = core_req_valid_i[i];
            core_req_ready_o[i] = gnt_d[i] & arb_o.ready;
        end
    end

    spm_fixed_prio_arb u_prio_arb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (valid_vec),
        .ready_i (arb_o.ready),
        .gnt_o   (gnt_d)
    );

    // One-hot AND-OR select
    // Request by current grant, abort and tag by last transfer
    always_comb begin
        req_acc   = '0;
        tag_acc   = '0;
        abort_acc = 1'b0;
        for (int i = 0; i < spm_pkg::NREQ; i++) begin
            req_acc   = req_acc | ({$bits(spm_pkg::spm_req_t){gnt_d[i]}} & core_req_i[i]);
            tag_acc   = tag_acc | ({spm_pkg::TAG_W{gnt_q[i]}} & core_req_tag_i[i]);
            abort_acc = abort_acc | (gnt_q[i] & core_req_abort_i[i]);
        end
    end

    assign arb_o.valid = |gnt_d;
    assign arb_o.req   = spm_pkg::spm_req_t'(req_acc);
    assign arb_o.tag   = tag_acc;
    assign arb_o.abort = abort_acc;

    // Who transferred on this edge, used for the tag phase
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= gnt_d & {spm_pkg::NREQ{arb_o.ready}};
        end
    end

    // Route response valid by source id, data shared
    always_comb begin
        for (int i = 0; i < spm_pkg::NREQ; i++) begin
            core_rsp_valid_o[i] = store_rsp_valid_i && (store_rsp_i.sid == spm_pkg::SID_W'(i));
        end
    end

    assign core_rsp_o = store_rsp_i;

    // Requester keeps valid until accepted
    for (genvar g = 0; g < spm_pkg::NREQ; g++) begin : g_valid_chk
        a_valid_hold: assert property (
            @(posedge clk_i) disable iff (!rst_ni)
            (core_req_valid_i[g] && !core_req_ready_o[g]) |=> core_req_valid_i[g]
        );
    end

endmodule

// File: hw/spm_fixed_prio_arb.sv
`timescale 1ns/1ps

module spm_fixed_prio_arb (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [spm_pkg::NREQ-1:0] req_i,
    input  logic                     ready_i,
    output logic [spm_pkg::NREQ-1:0] gnt_o
);

    logic [spm_pkg::NREQ-1:0] pick;
    logic [spm_pkg::NREQ-1:0] held_gnt_q;
    logic                     hold_q;

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = 0; i < spm_pkg::NREQ; i++) begin
            if (req_i[i] && (pick == '0)) begin
                pick[i] = 1'b1;
            end
        end
    end

    // Keep the previous grant while it was not accepted
    assign gnt_o = hold_q ? held_gnt_q : pick;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_q     <= 1'b0;
            held_gnt_q <= '0;
        end else begin
            // Pending grant stalled by downstream
            hold_q     <= (|gnt_o) && !ready_i;
            held_gnt_q <= gnt_o;
        end
    end

    // At most one winner
    a_gnt_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o)
    );

    // Stalled grant stays put, its requester still waiting
    a_gnt_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ((|gnt_o) && !ready_i) |=> ((gnt_o & req_i) == $past(gnt_o))
    );

endmodule

// File: hw/spm_req_if.sv
`timescale 1ns/1ps

interface spm_req_if;

    // First phase, granted request
    logic                 valid;
    logic                 ready;
    spm_pkg::spm_req_t    req;

    // Second phase, one cycle after the transfer
    logic                 abort;
    spm_pkg::spm_tag_t    tag;

    // Arbiter side
    modport arb (
        output valid,
        output req,
        output abort,
        output tag,
        input  ready
    );

    // Store side
    modport store (
        input  valid,
        input  req,
        input  abort,
        input  tag,
        output ready
    );

endinterface

// File: hw/spm_pkg.sv
package spm_pkg;

    // Number of requesters sharing the scratchpad
    localparam int unsigned NREQ = 3;

    // Identifier widths
    localparam int unsigned SID_W = 2;
    localparam int unsigned TID_W = 4;

    // Address split, low index in the request and tag one cycle later
    localparam int unsigned IDX_W = 4;
    localparam int unsigned TAG_W = 4;
    localparam int unsigned ADDR_W = TAG_W + IDX_W;

    // Data path
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W = DATA_W / 8;

    // Array depth, one word per address
    localparam int unsigned NWORDS = 1 << ADDR_W;

    // Operation
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } spm_op_e;

    typedef logic [SID_W-1:0] spm_sid_t;
    typedef logic [TID_W-1:0] spm_tid_t;
    typedef logic [TAG_W-1:0] spm_tag_t;

    // First phase of a request
    typedef struct packed {
        spm_op_e             op;
        logic [IDX_W-1:0]    idx;
        logic [BE_W-1:0]     be;
        logic [DATA_W-1:0]   wdata;
        spm_sid_t            sid;
        spm_tid_t            tid;
    } spm_req_t;

    // Response
    // rdata is zero for stores
    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        spm_sid_t            sid;
        spm_tid_t            tid;
        spm_op_e             op;
    } spm_rsp_t;

endpackage
